// File: all.f
hdl/shift_isa_pkg.sv
hdl/shift_pipe_pkg.sv
hdl/barrel_shifter.sv
hdl/operand_resolver.sv
hdl/mac_unit.sv
hdl/shift_stage.sv
sim/shift_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module shift_stage_tb \
        -f all.f -Mdir obj_dir -o shift_stage_tb_sim || exit 1

out=$(./obj_dir/shift_stage_tb_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Test passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/shift_stage_tb.sv
module shift_stage_tb
        import shift_isa_pkg::*;
        import shift_pipe_pkg::*;
();

        localparam int PHY_REGS      = 46;
        localparam int IDX_W         = $clog2(PHY_REGS);
        localparam int STALL_TIMEOUT = 40;

        // Eight amounts with the first one in the low byte.
        localparam logic [63:0] SHIFT_AMOUNTS = {8'd255, 8'd200, 8'd64, 8'd33,
                                                 8'd32, 8'd31, 8'd1, 8'd0};

        logic              i_clk = 1'b0;
        logic              i_reset;
        logic              i_clear_from_writeback;
        logic              i_data_stall;
        logic              i_clear_from_alu;
        issue_ctrl_t       i_ctrl;
        logic [IDX_W-1:0]  i_destination_index;
        operand_t          i_alu_source;
        operand_t          i_shift_source;
        operand_t          i_shift_length;
        operand_t          i_mem_srcdest;
        logic [WORD_W-1:0] i_alu_source_value;
        logic [WORD_W-1:0] i_shift_source_value;
        logic [WORD_W-1:0] i_shift_length_value;
        logic [WORD_W-1:0] i_mem_srcdest_value;
        logic [WORD_W-1:0] i_alu_value_nxt;
        issue_ctrl_t       o_ctrl;
        logic [IDX_W-1:0]  o_destination_index;
        shift_result_t     o_data;
        logic              o_stall;

        // Expected contents of the stage register.
        issue_ctrl_t       exp_ctrl;
        logic [IDX_W-1:0]  exp_idx;
        shift_result_t     exp_data;

        logic [31:0]       rand_state = 32'h5e59bac7;
        int                errors = 0;
        int                checks = 0;

        shift_stage shift_stage_i (.*);

        always
        begin
                #2 i_clk = ~i_clk;
        end

        function automatic logic [31:0] next_rand();
                rand_state = rand_state * 32'd1664525 + 32'd1013904223;
                return rand_state;
        endfunction

        // ==================================================
        // Reference model.
        // ==================================================
        function automatic logic bit_at(input logic [WORD_W-1:0] v, input int pos);
                logic [WORD_W-1:0] t;
                t = v >> pos;
                return t[0];
        endfunction

        function automatic shift_result_t shift_model(input logic [WORD_W-1:0] src,
                                                      input logic [7:0] amt,
                                                      input shift_op_t op);
                shift_result_t res;
                int            n;
                int            rot;
                res = '0;
                n   = int'(amt);
                rot = n % WORD_W;
                res.shifted_value = src;
                if (op == SH_RRX)
                begin
                        res.shifted_value = src >> 1;
                        res.shift_carry   = src[0];
                        res.rrx           = 1'b1;
                end
                else if (n == 0)
                        res.use_old_carry = 1'b1;
                else if (op == SH_LSL)
                begin
                        res.shifted_value = (n < WORD_W) ? src << n : '0;
                        if (n <= WORD_W)
                                res.shift_carry = bit_at(src, WORD_W - n);
                end
                else if (op == SH_LSR)
                begin
                        res.shifted_value = (n < WORD_W) ? src >> n : '0;
                        if (n <= WORD_W)
                                res.shift_carry = bit_at(src, n - 1);
                end
                else if (op == SH_ASR)
                begin
                        if (n < WORD_W)
                        begin
                                res.shifted_value = $signed(src) >>> n;
                                res.shift_carry   = bit_at(src, n - 1);
                        end
                        else
                        begin
                                res.shifted_value = {WORD_W{src[WORD_W-1]}};
                                res.shift_carry   = src[WORD_W-1];
                        end
                end
                else if (rot == 0)
                        res.shift_carry = src[WORD_W-1];
                else
                begin
                        res.shifted_value = (src >> rot) | (src << (WORD_W - rot));
                        res.shift_carry   = bit_at(src, rot - 1);
                end
                return res;
        endfunction

        // Forwarding against the instruction currently in the stage.
        function automatic logic [WORD_W-1:0] forward_model(input operand_t op,
                                                            input logic [WORD_W-1:0] issue_value);
                if (op.imm_en)
                        return op.value;
                if (exp_ctrl.cond != COND_NV && op.value[IDX_W-1:0] == exp_idx)
                        return i_alu_value_nxt;
                return issue_value;
        endfunction

        function automatic operand_t reg_op(input int idx);
                return '{imm_en: 1'b0, value: WORD_W'(idx)};
        endfunction

        function automatic operand_t imm_op(input logic [WORD_W-1:0] value);
                return '{imm_en: 1'b1, value: value};
        endfunction

        // ==================================================
        // Compare tasks.
        // ==================================================
        task automatic check_ctrl(input string name, input issue_ctrl_t got,
                                  input issue_ctrl_t exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_result(input string name, input shift_result_t got,
                                    input shift_result_t exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_index(input string name, input logic [IDX_W-1:0] got,
                                   input logic [IDX_W-1:0] exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
                end
        endtask

        // ==================================================
        // Drive and sample helpers.
        // ==================================================
        task automatic set_bubble();
                exp_ctrl      = '0;
                exp_ctrl.cond = COND_NV;
                exp_idx       = '0;
                exp_data      = '0;
        endtask

        task automatic compare_outputs();
                check_ctrl("o_ctrl", o_ctrl, exp_ctrl);
                check_index("o_destination_index", o_destination_index, exp_idx);
                check_result("o_data", o_data, exp_data);
        endtask

        task automatic drive_issue(input issue_ctrl_t ctrl, input int dest,
                                   input operand_t alu_src, input operand_t shift_src,
                                   input operand_t shift_len, input operand_t mem_src);
                @(posedge i_clk);
                i_ctrl               <= ctrl;
                i_destination_index  <= IDX_W'(dest);
                i_alu_source         <= alu_src;
                i_shift_source       <= shift_src;
                i_shift_length       <= shift_len;
                i_mem_srcdest        <= mem_src;
                i_alu_source_value   <= next_rand();
                i_shift_source_value <= next_rand();
                i_shift_length_value <= next_rand();
                i_mem_srcdest_value  <= next_rand();
                i_alu_value_nxt      <= next_rand();
        endtask

        task automatic set_flow(input logic stall, input logic wb_clear, input logic alu_clear);
                @(posedge i_clk);
                i_data_stall           <= stall;
                i_clear_from_writeback <= wb_clear;
                i_clear_from_alu       <= alu_clear;
        endtask

        // Expected load from the inputs held at the loading edge.
        task automatic predict_load();
                shift_result_t d;
                logic [7:0]    amt;
                amt = i_shift_length.imm_en ? i_shift_length.value[7:0]
                                            : i_shift_length_value[7:0];
                d   = shift_model(i_shift_source_value, amt, i_ctrl.shift_op);
                d.alu_source_value  = forward_model(i_alu_source, i_alu_source_value);
                d.mem_srcdest_value = forward_model(i_mem_srcdest, i_mem_srcdest_value);
                if (i_ctrl.alu_op == OP_MLA)
                        d.shifted_value = i_alu_source_value * i_shift_source_value +
                                          i_shift_length_value;
                else if (i_ctrl.disable_shifter)
                        d.shifted_value = forward_model(i_shift_source, i_shift_source_value);
                exp_ctrl = i_ctrl;
                if (i_ctrl.alu_op == OP_MLA)
                        exp_ctrl.alu_op = OP_MOV;
                exp_idx  = i_destination_index;
                exp_data = d;
        endtask

        task automatic load_and_check();
                @(posedge i_clk);
                @(negedge i_clk);
                predict_load();
                compare_outputs();
        endtask

        task automatic settle_and_compare();
                @(posedge i_clk);
                @(negedge i_clk);
                compare_outputs();
        endtask

        // ==================================================
        // Tests.
        // ==================================================
        task automatic test_reset();
                @(negedge i_clk);
                set_bubble();
                compare_outputs();
                check_flag("o_stall", o_stall, 1'b0);
        endtask

        task automatic test_shifts();
                issue_ctrl_t ctrl;
                ctrl = '{COND_AL, OP_ADD, SH_LSL, 1'b1, 1'b0};
                for (int o = 0; o < 5; o++)
                begin
                        ctrl.shift_op = shift_op_t'(3'(o));
                        for (int a = 0; a < 8; a++)
                        begin
                                drive_issue(ctrl, 7, reg_op(1), reg_op(2),
                                            imm_op(WORD_W'(8'(SHIFT_AMOUNTS >> (8 * a)))),
                                            reg_op(4));
                                load_and_check();
                        end
                        // Random amounts from the register value.
                        repeat (4)
                        begin
                                drive_issue(ctrl, 7, reg_op(1), reg_op(2), reg_op(3), reg_op(4));
                                load_and_check();
                        end
                end
                ctrl.disable_shifter = 1'b1;
                drive_issue(ctrl, 7, reg_op(1), reg_op(2), imm_op(32'd9), reg_op(4));
                load_and_check();
        endtask

        task automatic test_forwarding();
                issue_ctrl_t ctrl;
                ctrl = '{COND_AL, OP_ADD, SH_LSL, 1'b0, 1'b0};
                drive_issue(ctrl, 5, reg_op(1), reg_op(2), imm_op(32'd0), reg_op(4));
                load_and_check();
                // All three operands read the ALU result.
                ctrl.disable_shifter = 1'b1;
                drive_issue(ctrl, 5, reg_op(5), reg_op(5), imm_op(32'd0), reg_op(5));
                load_and_check();
                drive_issue(ctrl, 5, imm_op(32'd5), reg_op(5), imm_op(32'd0), reg_op(5));
                load_and_check();
                // Bubble that still names index 5.
                ctrl.cond = COND_NV;
                drive_issue(ctrl, 5, reg_op(1), reg_op(2), imm_op(32'd0), reg_op(4));
                load_and_check();
                // Empty stage, so the issue values stay.
                ctrl.cond = COND_AL;
                drive_issue(ctrl, 6, reg_op(5), reg_op(5), imm_op(32'd0), reg_op(5));
                load_and_check();
        endtask

        task automatic test_mla();
                issue_ctrl_t ctrl;
                int          cycles;
                ctrl = '{COND_AL, OP_MLA, SH_LSL, 1'b0, 1'b0};
                drive_issue(ctrl, 9, reg_op(1), reg_op(2), reg_op(3), reg_op(4));
                @(negedge i_clk);
                check_flag("o_stall", o_stall, 1'b1);
                // Stage takes bubbles while the unit runs.
                set_bubble();
                cycles = 0;
                while (o_stall && cycles < STALL_TIMEOUT)
                begin
                        @(negedge i_clk);
                        cycles++;
                        compare_outputs();
                end
                if (o_stall)
                begin
                        errors++;
                        $display("Timeout: o_stall still high %0d cycles after the MLA", cycles);
                end
                else
                begin
                        load_and_check();
                        check_flag("o_stall", o_stall, 1'b0);
                end
        endtask

        task automatic test_clear_stall();
                issue_ctrl_t ctrl;
                ctrl = '{COND_AL, OP_SUB, SH_LSR, 1'b1, 1'b0};
                drive_issue(ctrl, 11, reg_op(1), reg_op(2), imm_op(32'd3), reg_op(4));
                load_and_check();
                ctrl.alu_op = OP_AND;
                drive_issue(ctrl, 12, reg_op(1), reg_op(2), reg_op(3), reg_op(4));
                i_data_stall <= 1'b1;
                settle_and_compare();
                set_flow(1'b1, 1'b1, 1'b0);
                set_bubble();
                settle_and_compare();
                set_flow(1'b0, 1'b0, 1'b0);
                load_and_check();
                set_flow(1'b1, 1'b0, 1'b1);
                settle_and_compare();
                set_flow(1'b0, 1'b0, 1'b1);
                set_bubble();
                settle_and_compare();
                set_flow(1'b0, 1'b0, 1'b0);
        endtask

        initial
        begin
                issue_ctrl_t idle_ctrl;
                idle_ctrl      = '0;
                idle_ctrl.cond = COND_NV;
                i_reset                <= 1'b1;
                i_clear_from_writeback <= 1'b0;
                i_data_stall           <= 1'b0;
                i_clear_from_alu       <= 1'b0;
                i_ctrl                 <= idle_ctrl;
                i_destination_index    <= '0;
                i_alu_source           <= '0;
                i_shift_source         <= '0;
                i_shift_length         <= '0;
                i_mem_srcdest          <= '0;
                i_alu_source_value     <= '0;
                i_shift_source_value   <= '0;
                i_shift_length_value   <= '0;
                i_mem_srcdest_value    <= '0;
                i_alu_value_nxt        <= '0;
                set_bubble();
                repeat (3) @(posedge i_clk);
                i_reset <= 1'b0;
                test_reset();
                test_shifts();
                test_forwarding();
                test_mla();
                test_clear_stall();
                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("Test passed");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

// File: hdl/shift_stage.sv
module shift_stage
        import shift_isa_pkg::*;
        import shift_pipe_pkg::*;
#(
        parameter int  PHY_REGS      = 46,
        parameter int  MUL_STEP_BITS = 8,
        localparam int IDX_W         = $clog2(PHY_REGS)
)
(
        input  logic              i_clk,
        input  logic              i_reset,

        // Highest priority first.
        input  logic              i_clear_from_writeback,
        input  logic              i_data_stall,
        input  logic              i_clear_from_alu,

        // From issue.
        input  issue_ctrl_t       i_ctrl,
        input  logic [IDX_W-1:0]  i_destination_index,
        input  operand_t          i_alu_source,
        input  operand_t          i_shift_source,
        input  operand_t          i_shift_length,
        input  operand_t          i_mem_srcdest,
        input  logic [WORD_W-1:0] i_alu_source_value,
        input  logic [WORD_W-1:0] i_shift_source_value,
        input  logic [WORD_W-1:0] i_shift_length_value,
        input  logic [WORD_W-1:0] i_mem_srcdest_value,

        // From the ALU, for forwarding.
        input  logic [WORD_W-1:0] i_alu_value_nxt,

        output issue_ctrl_t       o_ctrl,
        output logic [IDX_W-1:0]  o_destination_index,
        output shift_result_t     o_data,
        output logic              o_stall
);

        localparam issue_ctrl_t CTRL_BUBBLE = '{
                cond:            COND_NV,
                alu_op:          '0,
                shift_op:        SH_LSL,
                flag_update:     1'b0,
                disable_shifter: 1'b0
        };

        logic [WORD_W-1:0] alu_source_res;
        logic [WORD_W-1:0] shift_source_res;
        logic [WORD_W-1:0] mem_srcdest_res;
        logic [WORD_W-1:0] shifter_out;
        logic              shifter_carry;
        logic              shifter_rrx;
        logic              shifter_old_carry;
        logic [WORD_W-1:0] mac_out;
        logic [7:0]        shift_amount;
        logic              is_mla;
        logic              take_bubble;
        issue_ctrl_t       ctrl_nxt;
        shift_result_t     data_nxt;

        assign is_mla = (i_ctrl.alu_op == OP_MLA);

        // ==================================================
        // Operands, shifter and multiplier.
        // ==================================================
        operand_resolver #(
                .PHY_REGS (PHY_REGS)
        ) operand_resolver_i (
                .i_alu_source              (i_alu_source),
                .i_shift_source            (i_shift_source),
                .i_mem_srcdest             (i_mem_srcdest),
                .i_alu_source_value        (i_alu_source_value),
                .i_shift_source_value      (i_shift_source_value),
                .i_mem_srcdest_value       (i_mem_srcdest_value),
                .i_stage_valid             (o_ctrl.cond != COND_NV),
                .i_stage_destination_index (o_destination_index),
                .i_alu_value_nxt           (i_alu_value_nxt),
                .o_alu_source_value        (alu_source_res),
                .o_shift_source_value      (shift_source_res),
                .o_mem_srcdest_value       (mem_srcdest_res)
        );

        // Immediate amounts come in the operand itself.
        assign shift_amount = i_shift_length.imm_en ? i_shift_length.value[7:0]
                                                    : i_shift_length_value[7:0];

        barrel_shifter barrel_shifter_i (
                .i_source        (i_shift_source_value),
                .i_amount        (shift_amount),
                .i_shift_op      (i_ctrl.shift_op),
                .o_result        (shifter_out),
                .o_carry         (shifter_carry),
                .o_rrx           (shifter_rrx),
                .o_use_old_carry (shifter_old_carry)
        );

        // rd = rm * rs + rn.
        mac_unit #(
                .MUL_STEP_BITS (MUL_STEP_BITS)
        ) mac_unit_i (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_clear (i_clear_from_writeback || i_clear_from_alu),
                .i_start (is_mla),
                .i_rm    (i_alu_source_value),
                .i_rs    (i_shift_source_value),
                .i_rn    (i_shift_length_value),
                .o_rd    (mac_out),
                .o_busy  (o_stall)
        );

        // ==================================================
        // Next stage contents.
        // ==================================================
        always_comb
        begin
                ctrl_nxt = i_ctrl;
                // ALU just moves the finished product.
                if (is_mla)
                        ctrl_nxt.alu_op = OP_MOV;

                data_nxt.alu_source_value  = alu_source_res;
                data_nxt.mem_srcdest_value = mem_srcdest_res;
                data_nxt.shift_carry       = shifter_carry;
                data_nxt.rrx               = shifter_rrx;
                data_nxt.use_old_carry     = shifter_old_carry;

                if (is_mla)
                        data_nxt.shifted_value = mac_out;
                else if (i_ctrl.disable_shifter)
                        data_nxt.shifted_value = shift_source_res;
                else
                        data_nxt.shifted_value = shifter_out;
        end

        // Writeback clear beats stall, stall beats ALU clear and MLA wait.
        assign take_bubble = i_reset || i_clear_from_writeback ||
                             (!i_data_stall && (i_clear_from_alu || o_stall));

        // ==================================================
        // Stage register.
        // ==================================================
        always_ff @(posedge i_clk)
        begin
                if (take_bubble)
                begin
                        o_ctrl              <= CTRL_BUBBLE;
                        o_destination_index <= '0;
                        o_data              <= '0;
                end
                else if (!i_data_stall)
                begin
                        o_ctrl              <= ctrl_nxt;
                        o_destination_index <= i_destination_index;
                        o_data              <= data_nxt;
                end
        end

        a_no_mla_out: assert property (@(posedge i_clk) disable iff (i_reset)
                o_ctrl.alu_op != OP_MLA);

endmodule

// File: hdl/mac_unit.sv
module mac_unit
        import shift_isa_pkg::*;
#(
        parameter int MUL_STEP_BITS = 8
)
(
        input  logic              i_clk,
        input  logic              i_reset,
        input  logic              i_clear,
        input  logic              i_start,
        input  logic [WORD_W-1:0] i_rm,
        input  logic [WORD_W-1:0] i_rs,
        input  logic [WORD_W-1:0] i_rn,
        output logic [WORD_W-1:0] o_rd,
        output logic              o_busy
);

        localparam int STEPS = WORD_W / MUL_STEP_BITS;
        localparam int CNT_W = $clog2(STEPS + 1);

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_RUN,
                ST_DONE
        } state_t;

        state_t            state_q;
        logic [CNT_W-1:0]  count_q;
        logic [WORD_W-1:0] rm_q;
        logic [WORD_W-1:0] rs_q;
        logic [WORD_W-1:0] acc_q;
        logic [WORD_W-1:0] partial;

        // One slice of rs against rm already moved into place.
        assign partial = rm_q * WORD_W'(rs_q[MUL_STEP_BITS-1:0]);

        // ==================================================
        // FSM.
        // ==================================================
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        state_q <= ST_IDLE;
                end
                else
                begin
                        case (state_q)
                        ST_IDLE:
                                if (i_start)
                                        state_q <= ST_RUN;
                        ST_RUN:
                                if (count_q == CNT_W'(STEPS - 1))
                                        state_q <= ST_DONE;
                        // Product stays put until the MLA leaves issue.
                        ST_DONE:
                                if (!i_start)
                                        state_q <= ST_IDLE;
                        default:
                                state_q <= ST_IDLE;
                        endcase
                end
        end

        // ==================================================
        // Accumulator.
        // ==================================================
        always_ff @(posedge i_clk)
        begin
                if (state_q == ST_IDLE)
                begin
                        rm_q    <= i_rm;
                        rs_q    <= i_rs;
                        acc_q   <= i_rn;
                        count_q <= '0;
                end
                else if (state_q == ST_RUN)
                begin
                        rm_q    <= rm_q << MUL_STEP_BITS;
                        rs_q    <= rs_q >> MUL_STEP_BITS;
                        acc_q   <= acc_q + partial;
                        count_q <= count_q + 1'b1;
                end
        end

        assign o_busy = (state_q == ST_IDLE && i_start) || (state_q == ST_RUN);
        assign o_rd   = acc_q;

        // Stage may load only once the product is final.
        a_done_not_busy: assert property (@(posedge i_clk) disable iff (i_reset)
                state_q == ST_DONE |-> !o_busy);

        // Issue drops i_start between two MLAs.
        a_done_no_restart: assert property (@(posedge i_clk) disable iff (i_reset)
                state_q == ST_DONE |-> !$rose(i_start));

endmodule

// File: hdl/operand_resolver.sv
module operand_resolver
        import shift_isa_pkg::*;
#(
        parameter int  PHY_REGS = 46,
        localparam int IDX_W    = $clog2(PHY_REGS)
)
(
        input  operand_t          i_alu_source,
        input  operand_t          i_shift_source,
        input  operand_t          i_mem_srcdest,
        input  logic [WORD_W-1:0] i_alu_source_value,
        input  logic [WORD_W-1:0] i_shift_source_value,
        input  logic [WORD_W-1:0] i_mem_srcdest_value,
        input  logic              i_stage_valid,
        input  logic [IDX_W-1:0]  i_stage_destination_index,
        input  logic [WORD_W-1:0] i_alu_value_nxt,
        output logic [WORD_W-1:0] o_alu_source_value,
        output logic [WORD_W-1:0] o_shift_source_value,
        output logic [WORD_W-1:0] o_mem_srcdest_value
);

        // Immediate first, then the result the ALU is making now.
        function automatic logic [WORD_W-1:0] resolve(
                input operand_t          op,
                input logic [WORD_W-1:0] issue_value,
                input logic              stage_valid,
                input logic [IDX_W-1:0]  stage_index,
                input logic [WORD_W-1:0] alu_value
        );
                logic hit;

                hit = stage_valid && (op.value[IDX_W-1:0] == stage_index);
                if (op.imm_en)
                        return op.value;
                else if (hit)
                        return alu_value;
                else
                        return issue_value;
        endfunction

        always_comb
        begin
                o_alu_source_value   = resolve(i_alu_source, i_alu_source_value,
                                               i_stage_valid, i_stage_destination_index,
                                               i_alu_value_nxt);
                o_shift_source_value = resolve(i_shift_source, i_shift_source_value,
                                               i_stage_valid, i_stage_destination_index,
                                               i_alu_value_nxt);
                // Store data is always a register.
                o_mem_srcdest_value  = resolve(i_mem_srcdest, i_mem_srcdest_value,
                                               i_stage_valid, i_stage_destination_index,
                                               i_alu_value_nxt);
        end

endmodule

// File: hdl/barrel_shifter.sv
module barrel_shifter
        import shift_isa_pkg::*;
(
        input  logic [WORD_W-1:0] i_source,
        input  logic [7:0]        i_amount,
        input  shift_op_t         i_shift_op,
        output logic [WORD_W-1:0] o_result,
        output logic              o_carry,
        output logic              o_rrx,
        output logic              o_use_old_carry
);

        logic [WORD_W:0]        lsl_ext;
        logic [WORD_W:0]        lsr_ext;
        logic signed [WORD_W:0] asr_ext;
        logic [2*WORD_W-1:0]    ror_ext;

        // ==================================================
        // Extended shifts.
        // ==================================================

        // One spare bit catches the last bit shifted out.
        assign lsl_ext = {1'b0, i_source} << i_amount;
        assign lsr_ext = {i_source, 1'b0} >> i_amount;

        // Sign fill covers amounts of 32 and above.
        assign asr_ext = $signed({i_source, 1'b0}) >>> i_amount;

        // Rotate by amount modulo 32.
        assign ror_ext = {i_source, i_source} >> i_amount[4:0];

        // ==================================================
        // Result and carry select.
        // ==================================================
        always_comb
        begin
                o_result        = i_source;
                o_carry         = 1'b0;
                o_rrx           = 1'b0;
                o_use_old_carry = 1'b0;

                if (i_shift_op == SH_RRX)
                begin
                        o_result = {1'b0, i_source[WORD_W-1:1]};
                        o_carry  = i_source[0];
                        o_rrx    = 1'b1;
                end
                else if (i_amount == 8'd0)
                begin
                        // Flags keep their current carry.
                        o_use_old_carry = 1'b1;
                end
                else
                begin
                        case (i_shift_op)
                        SH_LSL:
                                {o_carry, o_result} = lsl_ext;
                        SH_LSR:
                                {o_result, o_carry} = lsr_ext;
                        SH_ASR:
                                {o_result, o_carry} = asr_ext;
                        SH_ROR:
                                {o_carry, o_result} = {ror_ext[WORD_W-1], ror_ext[WORD_W-1:0]};
                        default:
                                o_use_old_carry = 1'b1;
                        endcase
                end
        end

endmodule

// File: hdl/shift_pipe_pkg.sv
package shift_pipe_pkg;

        import shift_isa_pkg::*;

        // ==================================================
        // Control fields, same layout on both sides.
        // ==================================================
        typedef struct packed {
                cond_t     cond;
                alu_op_t   alu_op;
                shift_op_t shift_op;
                logic      flag_update;
                logic      disable_shifter;
        } issue_ctrl_t;

        // ==================================================
        // Values handed on to the ALU.
        // ==================================================
        typedef struct packed {
                logic [WORD_W-1:0] alu_source_value;
                logic [WORD_W-1:0] shifted_value;
                logic [WORD_W-1:0] mem_srcdest_value;
                logic              shift_carry;
                // ALU inserts its own carry into bit 31.
                logic              rrx;
                logic              use_old_carry;
        } shift_result_t;

endpackage

// File: hdl/shift_isa_pkg.sv
package shift_isa_pkg;

        // ==================================================
        // Data path.
        // ==================================================
        localparam int WORD_W = 32;

        // Condition field. NV marks an empty stage.
        typedef logic [3:0] cond_t;

        localparam cond_t COND_AL = 4'hE;
        localparam cond_t COND_NV = 4'hF;

        // ==================================================
        // Operation codes.
        // ==================================================

        // Codes not listed here pass through the stage untouched.
        typedef logic [4:0] alu_op_t;

        localparam alu_op_t OP_AND = 5'd0;
        localparam alu_op_t OP_SUB = 5'd2;
        localparam alu_op_t OP_ADD = 5'd4;
        localparam alu_op_t OP_MOV = 5'd13;
        localparam alu_op_t OP_MLA = 5'd17;

        typedef enum logic [2:0] {
                SH_LSL = 3'd0,
                SH_LSR = 3'd1,
                SH_ASR = 3'd2,
                SH_ROR = 3'd3,
                SH_RRX = 3'd4
        } shift_op_t;

        // Register index in the low bits unless imm_en is set.
        typedef struct packed {
                logic              imm_en;
                logic [WORD_W-1:0] value;
        } operand_t;

endpackage
